// File: Bender.yml
package:
  name: crypto_scalar_fu

export_include_dirs:
  - design

sources:
  - files:
      - design/crypto_instr_pkg.sv
      - design/crypto_wb_pkg.sv
      - design/crypto_bitmanip.sv
      - design/crypto_sha256.sv
      - design/crypto_sm3.sv
      - design/crypto_result_stage.sv
      - design/crypto_scalar_fu.sv
  - target: test
    files:
      - bench/crypto_scalar_fu_asserts.sv
      - bench/crypto_scalar_fu_tb.sv

// File: bench/crypto_scalar_fu_asserts.sv
`timescale 1ns/1ps

module crypto_scalar_fu_asserts (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic                      valid_i,
  input crypto_instr_pkg::opcode_e opcode_i,
  input logic                      valid_o,
  input crypto_wb_pkg::word_t      result_o,
  input crypto_wb_pkg::id_t        id_o,
  input crypto_wb_pkg::rd_t        rd_o
);

  int unsigned violations = 0; // Failed checks so far

  reset_idle: assert property (@(posedge clk_i) !rst_ni |-> !valid_o)
    else begin
      violations++;
      $error("valid_o high while reset is asserted");
    end

  // Fixed one-cycle latency from issue to writeback
  valid_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
      valid_o == $past(valid_i && (opcode_i != crypto_instr_pkg::OP_NONE)))
    else begin
      violations++;
      $error("valid_o does not follow the issue of the previous cycle");
    end

  idle_zero: assert property (@(posedge clk_i)
      !valid_o |-> (result_o == '0 && id_o == '0 && rd_o == '0))
    else begin
      violations++;
      $error("Nonzero result, id or rd while valid_o is low");
    end

endmodule

// File: bench/crypto_scalar_fu_tb.sv
`timescale 1ns/1ps
`include "crypto_scalar_cfg.svh"

module crypto_scalar_fu_tb;

  localparam int unsigned CLK_PERIOD    = 100;
  localparam int unsigned N_RAND_BM     = 6;  // Per bitmanip sub-op
  localparam int unsigned N_RAND_HASH   = 6;  // Per hash function, after the two fixed words
  localparam int unsigned N_MIXED       = 32;
  localparam int unsigned N_GAPS        = 8;
  localparam int unsigned TOTAL_CYCLES  = 3 + 3 + 7 + 8 * N_RAND_BM + 6 * (N_RAND_HASH + 2)
                                          + N_MIXED + 4 * N_GAPS + 3;
  localparam int unsigned MARGIN_CYCLES = 20;
  localparam int unsigned TIMEOUT_NS    = (TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

  typedef struct packed {
    logic                 valid;
    crypto_wb_pkg::word_t result;
    crypto_wb_pkg::id_t   id;
    crypto_wb_pkg::rd_t   rd;
  } expect_t;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      valid_i;
  crypto_instr_pkg::opcode_e opcode_i;
  logic [31:0]               instr_i;
  crypto_wb_pkg::word_t      rs1_i;
  crypto_wb_pkg::word_t      rs2_i;
  crypto_wb_pkg::id_t        id_i;
  crypto_wb_pkg::rd_t        rd_i;
  logic                      valid_o;
  crypto_wb_pkg::word_t      result_o;
  crypto_wb_pkg::id_t        id_o;
  crypto_wb_pkg::rd_t        rd_o;

  expect_t     expected_q[$];
  bit          check_armed = 1'b0; // An entry was issued at the previous edge
  logic [31:0] lcg_state   = 32'd40762;

  crypto_scalar_fu i_dut (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .valid_i  (valid_i),
    .opcode_i (opcode_i),
    .instr_i  (instr_i),
    .rs1_i    (rs1_i),
    .rs2_i    (rs2_i),
    .id_i     (id_i),
    .rd_i     (rd_i),
    .valid_o  (valid_o),
    .result_o (result_o),
    .id_o     (id_o),
    .rd_o     (rd_o)
  );

  bind crypto_result_stage crypto_scalar_fu_asserts i_asserts (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .valid_i  (valid_i),
    .opcode_i (opcode_i),
    .valid_o  (valid_o),
    .result_o (result_o),
    .id_o     (id_o),
    .rd_o     (rd_o)
  );

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic crypto_wb_pkg::word_t rot_right(input crypto_wb_pkg::word_t x,
                                                     input int n);
    logic [2*`CRYPTO_XLEN-1:0] dbl;
    dbl = {x, x} >> n;
    return dbl[`CRYPTO_XLEN-1:0];
  endfunction

  function automatic crypto_wb_pkg::word_t rot_left(input crypto_wb_pkg::word_t x, input int n);
    return rot_right(x, `CRYPTO_XLEN - n);
  endfunction

  ////////////////////
  // Reference model
  ////////////////////

  function automatic crypto_wb_pkg::word_t ref_result(input crypto_instr_pkg::opcode_e opcode,
                                                      input logic [31:0] instr,
                                                      input crypto_wb_pkg::word_t rs1,
                                                      input crypto_wb_pkg::word_t rs2);
    crypto_wb_pkg::word_t res;
    int                   idx;
    res = '0;
    case (opcode)
      crypto_instr_pkg::OP_BITMANIP: begin
        case (crypto_instr_pkg::bitmanip_op_e'(instr[14:12]))
          crypto_instr_pkg::BM_BREV8:
            for (int i = 0; i < 32; i++) res[i] = rs1[(i / 8) * 8 + 7 - i % 8];
          crypto_instr_pkg::BM_PACK:  res = {rs2[15:0], rs1[15:0]};
          crypto_instr_pkg::BM_PACKH: res = {16'h0000, rs2[7:0], rs1[7:0]};
          crypto_instr_pkg::BM_XPERM4:
            for (int n = 0; n < 8; n++) begin
              idx = rs2[4*n +: 4];
              if (idx < 8) res[4*n +: 4] = 4'(rs1 >> (4 * idx));
            end
          crypto_instr_pkg::BM_XPERM8:
            for (int b = 0; b < 4; b++) begin
              idx = rs2[8*b +: 8];
              if (idx < 4) res[8*b +: 8] = 8'(rs1 >> (8 * idx));
            end
          crypto_instr_pkg::BM_ZIP:
            for (int i = 0; i < 16; i++) begin
              res[2*i]     = rs1[i];
              res[2*i + 1] = rs1[i + 16];
            end
          crypto_instr_pkg::BM_UNZIP:
            for (int i = 0; i < 16; i++) begin
              res[i]      = rs1[2*i];
              res[i + 16] = rs1[2*i + 1];
            end
          default: res = '0; // Reserved
        endcase
      end
      crypto_instr_pkg::OP_SHA256: begin
        case (crypto_instr_pkg::sha256_op_e'(instr[21:20]))
          crypto_instr_pkg::SUM0: res = rot_right(rs1, 2) ^ rot_right(rs1, 13) ^ rot_right(rs1, 22);
          crypto_instr_pkg::SUM1: res = rot_right(rs1, 6) ^ rot_right(rs1, 11) ^ rot_right(rs1, 25);
          crypto_instr_pkg::SIG0: res = rot_right(rs1, 7) ^ rot_right(rs1, 18) ^ (rs1 >> 3);
          default:                res = rot_right(rs1, 17) ^ rot_right(rs1, 19) ^ (rs1 >> 10);
        endcase
      end
      crypto_instr_pkg::OP_SM3: begin
        if (instr[20]) res = rs1 ^ rot_left(rs1, 15) ^ rot_left(rs1, 23); // P1
        else           res = rs1 ^ rot_left(rs1, 9) ^ rot_left(rs1, 17);
      end
      default: res = '0;
    endcase
    return res;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic issue_op(input logic valid, input crypto_instr_pkg::opcode_e opcode,
                          input logic [31:0] instr, input crypto_wb_pkg::word_t rs1,
                          input crypto_wb_pkg::word_t rs2, input crypto_wb_pkg::id_t id,
                          input crypto_wb_pkg::rd_t rd);
    expect_t e;
    @(negedge clk_i);
    valid_i  = valid;
    opcode_i = opcode;
    instr_i  = instr;
    rs1_i    = rs1;
    rs2_i    = rs2;
    id_i     = id;
    rd_i     = rd;
    e.valid  = valid && (opcode != crypto_instr_pkg::OP_NONE);
    e.result = e.valid ? ref_result(opcode, instr, rs1, rs2) : '0;
    e.id     = e.valid ? id : '0;
    e.rd     = e.valid ? rd : '0;
    expected_q.push_back(e);
  endtask

  task automatic issue_valid(input crypto_instr_pkg::opcode_e opcode, input logic [31:0] instr,
                             input crypto_wb_pkg::word_t rs1, input crypto_wb_pkg::word_t rs2);
    logic [31:0] r;
    r = next_random();
    issue_op(1'b1, opcode, instr, rs1, rs2, r[19:16], r[24:20]);
  endtask

  task automatic issue_idle();
    issue_op(1'b0, crypto_instr_pkg::OP_NONE, '0, '0, '0, '0, '0);
  endtask

  function automatic logic [31:0] bm_instr(input logic [2:0] op);
    logic [31:0] w;
    w        = next_random();
    w[14:12] = op;
    return w;
  endfunction

  function automatic logic [31:0] hash_instr(input logic [1:0] sel);
    logic [31:0] w;
    w        = next_random();
    w[21:20] = sel;
    return w;
  endfunction

  // Result of the issue at the previous edge is stable until the current one
  always @(posedge clk_i) begin
    expect_t e;
    if (check_armed) begin
      e = expected_q.pop_front();
      check_value("valid_o", 32'(valid_o), 32'(e.valid));
      check_value("result_o", result_o, e.result);
      check_value("id_o", 32'(id_o), 32'(e.id));
      check_value("rd_o", 32'(rd_o), 32'(e.rd));
    end
    check_armed = (expected_q.size() != 0);
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Error: the run timed out after %0t ns before all results came back", $time);
    $display("Simulation FAILED");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    logic [31:0]               w;
    logic [31:0]               r;
    crypto_wb_pkg::word_t      rs1;
    crypto_wb_pkg::word_t      rs2;
    crypto_instr_pkg::opcode_e opc;
    rst_ni   = 1'b1;
    valid_i  = 1'b0;
    opcode_i = crypto_instr_pkg::OP_NONE;
    instr_i  = '0;
    rs1_i    = '0;
    rs2_i    = '0;
    id_i     = '0;
    rd_i     = '0;
    #10 rst_ni = 1'b0; // Clean falling edge before the first clock
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // Outputs straight out of reset
    check_value("valid_o", 32'(valid_o), 32'd0);
    check_value("result_o", result_o, 32'd0);
    check_value("id_o", 32'(id_o), 32'd0);
    check_value("rd_o", 32'(rd_o), 32'd0);
    repeat (3) issue_idle();

    ////////////////////
    // Bit manipulation
    ////////////////////
    w = 32'h8421_F0C3;
    issue_valid(crypto_instr_pkg::OP_BITMANIP, bm_instr(3'd5), w, next_random());
    rs1 = ref_result(crypto_instr_pkg::OP_BITMANIP, {17'd0, 3'd5, 12'd0}, w, '0);
    issue_valid(crypto_instr_pkg::OP_BITMANIP, bm_instr(3'd6), rs1, next_random());
    issue_valid(crypto_instr_pkg::OP_BITMANIP, bm_instr(3'd0), 32'hFF0F_01FF, next_random());
    issue_valid(crypto_instr_pkg::OP_BITMANIP, bm_instr(3'd0), 32'hFFFF_FFFF, next_random());
    issue_valid(crypto_instr_pkg::OP_BITMANIP, bm_instr(3'd4), 32'hDDCC_BBAA, 32'h0403_FF00);
    issue_valid(crypto_instr_pkg::OP_BITMANIP, bm_instr(3'd3), 32'h7654_3210, 32'h8F09_7A31);
    issue_valid(crypto_instr_pkg::OP_BITMANIP, bm_instr(3'd7), 32'hFFFF_FFFF, 32'hFFFF_FFFF);
    for (int op = 0; op < 8; op++) begin
      for (int i = 0; i < N_RAND_BM; i++) begin
        r = next_random();
        rs2 = (i % 2) ? (r & 32'h0303_0707) : r; // Odd cases keep xperm indices in range
        issue_valid(crypto_instr_pkg::OP_BITMANIP, bm_instr(3'(op)), next_random(), rs2);
      end
    end

    ////////////////////
    // SHA-256 and SM3
    ////////////////////
    for (int f = 0; f < 6; f++) begin
      opc = (f < 4) ? crypto_instr_pkg::OP_SHA256 : crypto_instr_pkg::OP_SM3;
      for (int j = 0; j < N_RAND_HASH + 2; j++) begin
        if (j == 0)      rs1 = 32'h0000_0001;
        else if (j == 1) rs1 = 32'h8000_0000;
        else             rs1 = next_random();
        issue_valid(opc, hash_instr(2'(f % 4)), rs1, next_random());
      end
    end

    // Back-to-back issues across all units
    for (int i = 0; i < N_MIXED; i++) begin
      r = next_random();
      opc = (r[31:30] == 2'd0) ? crypto_instr_pkg::OP_SM3 : crypto_instr_pkg::opcode_e'(r[31:30]);
      issue_valid(opc, next_random(), next_random(), next_random());
    end

    // OP_NONE issues and idle cycles carrying live data
    for (int i = 0; i < N_GAPS; i++) begin
      issue_valid(crypto_instr_pkg::OP_SM3, next_random(), next_random(), next_random());
      issue_op(1'b0, crypto_instr_pkg::OP_SHA256, next_random(), next_random(), next_random(),
               4'hF, 5'h1F);
      issue_valid(crypto_instr_pkg::OP_NONE, next_random(), next_random(), next_random());
      issue_idle();
    end

    repeat (3) issue_idle();
    while (expected_q.size() != 0) @(negedge clk_i);

    if (i_dut.i_result_stage.i_asserts.violations == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("Error: %0d assertion failures were seen",
               i_dut.i_result_stage.i_asserts.violations);
      $display("Simulation FAILED");
      $fatal(1, "Assertion failures");
    end
  end

endmodule

// File: crypto_scalar_fu.f
+incdir+design
design/crypto_instr_pkg.sv
design/crypto_wb_pkg.sv
design/crypto_bitmanip.sv
design/crypto_sha256.sv
design/crypto_sm3.sv
design/crypto_result_stage.sv
design/crypto_scalar_fu.sv
bench/crypto_scalar_fu_asserts.sv
bench/crypto_scalar_fu_tb.sv

// File: design/crypto_bitmanip.sv
`timescale 1ns/1ps
`include "crypto_scalar_cfg.svh"

module crypto_bitmanip (
  input  logic [31:0]          instr_i,
  input  crypto_wb_pkg::word_t rs1_i,
  input  crypto_wb_pkg::word_t rs2_i,
  output crypto_wb_pkg::word_t result_o
);

  crypto_instr_pkg::bitmanip_op_e op;

  crypto_wb_pkg::word_t brev8_res;
  crypto_wb_pkg::word_t pack_res;
  crypto_wb_pkg::word_t packh_res;
  crypto_wb_pkg::word_t xperm4_res;
  crypto_wb_pkg::word_t xperm8_res;
  crypto_wb_pkg::word_t zip_res;
  crypto_wb_pkg::word_t unzip_res;

  assign op = crypto_instr_pkg::bitmanip_op_e'(instr_i[14:12]); // funct3 field

  ////////////////////
  // Byte-wise ops
  ////////////////////

  always_comb begin
    for (int b = 0; b < `CRYPTO_XLEN / 8; b++) begin
      for (int i = 0; i < 8; i++) begin
        brev8_res[8*b + i] = rs1_i[8*b + 7 - i]; // Mirror within byte
      end
    end
  end

  assign pack_res  = {rs2_i[`CRYPTO_XLEN/2-1:0], rs1_i[`CRYPTO_XLEN/2-1:0]};
  assign packh_res = {{(`CRYPTO_XLEN-16){1'b0}}, rs2_i[7:0], rs1_i[7:0]};

  ////////////////////
  // Crossbar permutes
  ////////////////////

  // Each lane of rs2 picks one lane of rs1; indices past the word read zero
  always_comb begin
    for (int b = 0; b < `CRYPTO_XLEN / 8; b++) begin
      if (rs2_i[8*b +: 8] < (`CRYPTO_XLEN / 8)) begin
        xperm8_res[8*b +: 8] = rs1_i[8*rs2_i[8*b +: 2] +: 8];
      end else begin
        xperm8_res[8*b +: 8] = 8'h00; // Out of range
      end
    end
  end

  always_comb begin
    for (int n = 0; n < `CRYPTO_XLEN / 4; n++) begin
      if (rs2_i[4*n +: 4] < (`CRYPTO_XLEN / 4)) begin
        xperm4_res[4*n +: 4] = rs1_i[4*rs2_i[4*n +: 3] +: 4];
      end else begin
        xperm4_res[4*n +: 4] = 4'h0; // Index 8 and up
      end
    end
  end

  ////////////////////
  // Bit interleave
  ////////////////////

  always_comb begin
    for (int i = 0; i < `CRYPTO_XLEN / 2; i++) begin
      zip_res[2*i]                   = rs1_i[i];                   // Low half to even bits
      zip_res[2*i + 1]               = rs1_i[i + `CRYPTO_XLEN/2];  // High half to odd bits
      unzip_res[i]                   = rs1_i[2*i];
      unzip_res[i + `CRYPTO_XLEN/2]  = rs1_i[2*i + 1];
    end
  end

  always_comb begin
    case (op)
      crypto_instr_pkg::BM_BREV8:  result_o = brev8_res;
      crypto_instr_pkg::BM_PACK:   result_o = pack_res;
      crypto_instr_pkg::BM_PACKH:  result_o = packh_res;
      crypto_instr_pkg::BM_XPERM4: result_o = xperm4_res;
      crypto_instr_pkg::BM_XPERM8: result_o = xperm8_res;
      crypto_instr_pkg::BM_ZIP:    result_o = zip_res;
      crypto_instr_pkg::BM_UNZIP:  result_o = unzip_res;
      default:                     result_o = '0; // Reserved encoding
    endcase
  end

endmodule

// File: design/crypto_instr_pkg.sv
package crypto_instr_pkg;

  // Execution unit selected at issue
  typedef enum logic [1:0] {
    OP_NONE     = 2'd0,
    OP_BITMANIP = 2'd1,
    OP_SHA256   = 2'd2,
    OP_SM3      = 2'd3
  } opcode_e;

  // Bit-manipulation sub-operation, instr[14:12]
  typedef enum logic [2:0] {
    BM_BREV8    = 3'd0,
    BM_PACK     = 3'd1,
    BM_PACKH    = 3'd2,
    BM_XPERM4   = 3'd3,
    BM_XPERM8   = 3'd4,
    BM_ZIP      = 3'd5,
    BM_UNZIP    = 3'd6,
    BM_RESERVED = 3'd7
  } bitmanip_op_e;

  // SHA-256 sub-operation, instr[21:20]
  typedef enum logic [1:0] {
    SUM0 = 2'd0,
    SUM1 = 2'd1,
    SIG0 = 2'd2,
    SIG1 = 2'd3
  } sha256_op_e;

  // SM3 sub-operation, instr[20]
  typedef enum logic {
    P0 = 1'b0,
    P1 = 1'b1
  } sm3_op_e;

endpackage

// File: design/crypto_result_stage.sv
`timescale 1ns/1ps

module crypto_result_stage (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       valid_i,
  input  crypto_instr_pkg::opcode_e  opcode_i,
  input  crypto_wb_pkg::id_t         id_i,
  input  crypto_wb_pkg::rd_t         rd_i,
  input  crypto_wb_pkg::word_t       bitmanip_result_i,
  input  crypto_wb_pkg::word_t       sha256_result_i,
  input  crypto_wb_pkg::word_t       sm3_result_i,
  output logic                       valid_o,
  output crypto_wb_pkg::word_t       result_o,
  output crypto_wb_pkg::id_t         id_o,
  output crypto_wb_pkg::rd_t         rd_o
);

  crypto_wb_pkg::word_t unit_result;

  logic                 valid_d;
  crypto_wb_pkg::word_t result_d;
  crypto_wb_pkg::id_t   id_d;
  crypto_wb_pkg::rd_t   rd_d;

  logic                 valid_q;
  crypto_wb_pkg::word_t result_q;
  crypto_wb_pkg::id_t   id_q;
  crypto_wb_pkg::rd_t   rd_q;

  ////////////////////
  // Result select
  ////////////////////

  always_comb begin
    case (opcode_i)
      crypto_instr_pkg::OP_BITMANIP: unit_result = bitmanip_result_i;
      crypto_instr_pkg::OP_SHA256:   unit_result = sha256_result_i;
      crypto_instr_pkg::OP_SM3:      unit_result = sm3_result_i;
      default:                       unit_result = '0;
    endcase
  end

  assign valid_d = valid_i && (opcode_i != crypto_instr_pkg::OP_NONE);

  // Idle and OP_NONE cycles write back an all-zero bundle
  assign result_d = valid_d ? unit_result : '0;
  assign id_d     = valid_d ? id_i : '0;
  assign rd_d     = valid_d ? rd_i : '0;

  ////////////////////
  // Writeback register
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= 1'b0;
      result_q <= '0;
      id_q     <= '0;
      rd_q     <= '0;
    end else begin
      valid_q  <= valid_d;
      result_q <= result_d;
      id_q     <= id_d;
      rd_q     <= rd_d;
    end
  end

  assign valid_o  = valid_q;
  assign result_o = result_q;
  assign id_o     = id_q;
  assign rd_o     = rd_q;

endmodule

// File: design/crypto_scalar_cfg.svh
`ifndef CRYPTO_SCALAR_CFG_SVH
`define CRYPTO_SCALAR_CFG_SVH

// Datapath word width
`define CRYPTO_XLEN 32

// Instruction tag returned with the result
`define CRYPTO_ID_W 4

// Destination register address
`define CRYPTO_RD_W 5

`endif

// File: design/crypto_scalar_fu.sv
`timescale 1ns/1ps

module crypto_scalar_fu (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      valid_i,
  input  crypto_instr_pkg::opcode_e opcode_i,
  input  logic [31:0]               instr_i,
  input  crypto_wb_pkg::word_t      rs1_i,
  input  crypto_wb_pkg::word_t      rs2_i,
  input  crypto_wb_pkg::id_t        id_i,
  input  crypto_wb_pkg::rd_t        rd_i,
  output logic                      valid_o,
  output crypto_wb_pkg::word_t      result_o,
  output crypto_wb_pkg::id_t        id_o,
  output crypto_wb_pkg::rd_t        rd_o
);

  crypto_wb_pkg::word_t bitmanip_result;
  crypto_wb_pkg::word_t sha256_result;
  crypto_wb_pkg::word_t sm3_result;

  ////////////////////
  // Execution units
  ////////////////////

  crypto_bitmanip i_bitmanip (
    .instr_i  (instr_i),
    .rs1_i    (rs1_i),
    .rs2_i    (rs2_i),
    .result_o (bitmanip_result)
  );

  crypto_sha256 i_sha256 (
    .instr_i  (instr_i),
    .rs1_i    (rs1_i),
    .result_o (sha256_result)
  );

  crypto_sm3 i_sm3 (
    .instr_i  (instr_i),
    .rs1_i    (rs1_i),
    .result_o (sm3_result)
  );

  crypto_result_stage i_result_stage (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .valid_i           (valid_i),
    .opcode_i          (opcode_i),
    .id_i              (id_i),
    .rd_i              (rd_i),
    .bitmanip_result_i (bitmanip_result),
    .sha256_result_i   (sha256_result),
    .sm3_result_i      (sm3_result),
    .valid_o           (valid_o),
    .result_o          (result_o),
    .id_o              (id_o),
    .rd_o              (rd_o)
  );

endmodule

// File: design/crypto_sha256.sv
`timescale 1ns/1ps
`include "crypto_scalar_cfg.svh"

module crypto_sha256 (
  input  logic [31:0]          instr_i,
  input  crypto_wb_pkg::word_t rs1_i,
  output crypto_wb_pkg::word_t result_o
);

  crypto_instr_pkg::sha256_op_e op;

  crypto_wb_pkg::word_t sum0;
  crypto_wb_pkg::word_t sum1;
  crypto_wb_pkg::word_t sig0;
  crypto_wb_pkg::word_t sig1;

  function automatic crypto_wb_pkg::word_t ror(input crypto_wb_pkg::word_t x,
                                               input int unsigned n);
    return (x >> n) | (x << (`CRYPTO_XLEN - n));
  endfunction

  assign op = crypto_instr_pkg::sha256_op_e'(instr_i[21:20]); // Select in rs2 field

  // Compression round functions
  assign sum0 = ror(rs1_i, 2) ^ ror(rs1_i, 13) ^ ror(rs1_i, 22);
  assign sum1 = ror(rs1_i, 6) ^ ror(rs1_i, 11) ^ ror(rs1_i, 25);

  // Message schedule functions
  assign sig0 = ror(rs1_i, 7) ^ ror(rs1_i, 18) ^ (rs1_i >> 3);
  assign sig1 = ror(rs1_i, 17) ^ ror(rs1_i, 19) ^ (rs1_i >> 10);

  always_comb begin
    case (op)
      crypto_instr_pkg::SUM0: result_o = sum0;
      crypto_instr_pkg::SUM1: result_o = sum1;
      crypto_instr_pkg::SIG0: result_o = sig0;
      default:                result_o = sig1;
    endcase
  end

endmodule

// File: design/crypto_sm3.sv
`timescale 1ns/1ps
`include "crypto_scalar_cfg.svh"

module crypto_sm3 (
  input  logic [31:0]          instr_i,
  input  crypto_wb_pkg::word_t rs1_i,
  output crypto_wb_pkg::word_t result_o
);

  crypto_instr_pkg::sm3_op_e op;

  crypto_wb_pkg::word_t p0;
  crypto_wb_pkg::word_t p1;

  function automatic crypto_wb_pkg::word_t rol(input crypto_wb_pkg::word_t x,
                                               input int unsigned n);
    return (x << n) | (x >> (`CRYPTO_XLEN - n));
  endfunction

  assign op = crypto_instr_pkg::sm3_op_e'(instr_i[20]);

  assign p0 = rs1_i ^ rol(rs1_i, 9) ^ rol(rs1_i, 17);  // Compression permutation
  assign p1 = rs1_i ^ rol(rs1_i, 15) ^ rol(rs1_i, 23); // Expansion permutation

  assign result_o = (op == crypto_instr_pkg::P1) ? p1 : p0;

endmodule

// File: design/crypto_wb_pkg.sv
`include "crypto_scalar_cfg.svh"

package crypto_wb_pkg;

  // Operand and result word
  typedef logic [`CRYPTO_XLEN-1:0] word_t;

  // Tag handed back to the issuing core
  typedef logic [`CRYPTO_ID_W-1:0] id_t;

  // Destination register index
  typedef logic [`CRYPTO_RD_W-1:0] rd_t;

endpackage
